/* rtl/time_pkg.sv */
////////////////////////////////////////////////////////////
// Time types of the node
// Absolute time, update offset and the counter control word
////////////////////////////////////////////////////////////

package time_pkg;

   localparam int TIME_W   = 48;  // Absolute time in ticks
   localparam int OFFSET_W = 32;

   // Absolute time in user_clock ticks
   typedef logic [TIME_W-1:0]   time_t;

   // Offset added on an update command
   typedef logic [OFFSET_W-1:0] offset_t;

   ////////////////////////////////////////////////////////////
   // Counter control, one strobe per cycle at most
   typedef struct packed {
      logic  clear;  // Back to zero
      logic  load;   // Take value as new time
      logic  add;    // Add low OFFSET_W bits of value
      time_t value;
   } time_ctrl_t;

endpackage

/* rtl/tnet_node.sv */
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// Timing network node top
// Decoder, time counter and transmit builder
////////////////////////////////////////////////////////////

module tnet_node
   import time_pkg::*, tnet_pkg::*;
#(
   parameter node_id_t NODE_ID = 9'd3
)(
   input  logic      user_clock,
   input  logic      reset_1,
   input  tnet_pkt_t rx_pkt_i,
   input  logic      rx_valid_i,
   input  logic      tx_ready_i,
   output tnet_pkt_t tx_pkt_o,
   output logic      tx_valid_o,
   output time_t     time_o,
   output logic      drop_o
);

   time_ctrl_t time_ctrl;
   time_t      time_abs;
   logic       req_valid;
   logic       req_forward;
   logic       req_reply;
   tnet_pkt_t  req_pkt;

   assign time_o = time_abs;

   tnet_rx_decoder #(
      .NODE_ID (NODE_ID)
   ) decoder_inst (
      .user_clock    (user_clock),
      .reset_1       (reset_1),
      .rx_pkt_i      (rx_pkt_i),
      .rx_valid_i    (rx_valid_i),
      .time_ctrl_o   (time_ctrl),
      .req_valid_o   (req_valid),
      .req_forward_o (req_forward),
      .req_reply_o   (req_reply),
      .req_pkt_o     (req_pkt)
   );

   tnet_time_counter counter_inst (
      .user_clock  (user_clock),
      .reset_1     (reset_1),
      .time_ctrl_i (time_ctrl),
      .time_o      (time_abs)
   );

   // Builder samples the counter before its update
   tnet_tx_builder #(
      .NODE_ID (NODE_ID)
   ) builder_inst (
      .user_clock    (user_clock),
      .reset_1       (reset_1),
      .req_valid_i   (req_valid),
      .req_forward_i (req_forward),
      .req_reply_i   (req_reply),
      .req_pkt_i     (req_pkt),
      .time_i        (time_abs),
      .tx_ready_i    (tx_ready_i),
      .tx_pkt_o      (tx_pkt_o),
      .tx_valid_o    (tx_valid_o),
      .drop_o        (drop_o)
   );

endmodule

/* rtl/tnet_pkg.sv */
////////////////////////////////////////////////////////////
// Ring packet definitions
// Header fields, packet layout, commands, transmit FSM states
////////////////////////////////////////////////////////////

package tnet_pkg;

   localparam int NODE_ID_W = 9;
   localparam int PAYLOAD_W = 96;

   typedef logic [NODE_ID_W-1:0] node_id_t;
   typedef logic [2:0]           pkt_type_t;
   typedef logic [4:0]           pkt_flags_t;
   typedef logic [PAYLOAD_W-1:0] payload_t;

   // All ones addresses every node
   localparam node_id_t BCAST_ID = '1;

   ////////////////////////////////////////////////////////////
   // Commands handled by the node
   typedef enum logic [5:0] {
      CMD_NOP         = 6'd0,
      CMD_RST_TIME    = 6'd1,
      CMD_SET_TIME    = 6'd2,
      CMD_UPDT_OFFSET = 6'd9,
      CMD_GET_TIME    = 6'd11,
      CMD_TIME_REPLY  = 6'd12
   } tnet_cmd_e;

   // 128-bit ring word, header on top
   typedef struct packed {
      pkt_type_t  ptype;
      tnet_cmd_e  cmd;
      pkt_flags_t flags;
      node_id_t   src;
      node_id_t   dst;
      payload_t   payload;
   } tnet_pkt_t;

   // Transmit register owner
   typedef enum logic {
      TX_IDLE,
      TX_HOLD   // Packet waiting for ready
   } tx_state_e;

endpackage

/* rtl/tnet_rx_decoder.sv */
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// Receive decoder
// Destination check, time control strobes, transmit requests
////////////////////////////////////////////////////////////

module tnet_rx_decoder
   import time_pkg::*, tnet_pkg::*;
#(
   parameter node_id_t NODE_ID = '0
)(
   input  logic       user_clock,
   input  logic       reset_1,
   input  tnet_pkt_t  rx_pkt_i,
   input  logic       rx_valid_i,
   output time_ctrl_t time_ctrl_o,
   output logic       req_valid_o,
   output logic       req_forward_o,
   output logic       req_reply_o,
   output tnet_pkt_t  req_pkt_o
);

   logic       is_bcast;
   logic       is_own;
   logic       is_exec;
   logic       is_fwd;
   logic       is_reply;
   time_ctrl_t ctrl_d;

   ////////////////////////////////////////////////////////////
   // Destination classes
   assign is_bcast = (rx_pkt_i.dst == BCAST_ID);
   assign is_own   = (rx_pkt_i.dst == NODE_ID) && !is_bcast;
   assign is_exec  = is_own || is_bcast;
   assign is_fwd   = !is_own;                    // Broadcast and foreign
   assign is_reply = is_own && (rx_pkt_i.cmd == CMD_GET_TIME);

   // Command to counter strobes
   always_comb begin
      ctrl_d       = '0;
      ctrl_d.value = rx_pkt_i.payload[TIME_W-1:0];
      if (rx_valid_i && is_exec) begin
         case (rx_pkt_i.cmd)
            CMD_RST_TIME:    ctrl_d.clear = 1'b1;
            CMD_SET_TIME:    ctrl_d.load  = 1'b1;
            CMD_UPDT_OFFSET: ctrl_d.add   = 1'b1;
            default:         ctrl_d.clear = 1'b0;  // Other commands leave time alone
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // Registered outputs, one cycle per received packet
   always_ff @(posedge user_clock) begin
      if (reset_1) begin
         time_ctrl_o   <= '0;
         req_valid_o   <= 1'b0;
         req_forward_o <= 1'b0;
         req_reply_o   <= 1'b0;
      end else begin
         time_ctrl_o   <= ctrl_d;
         req_valid_o   <= rx_valid_i && (is_fwd || is_reply);
         req_forward_o <= rx_valid_i && is_fwd;
         req_reply_o   <= rx_valid_i && is_reply;
      end
   end

   // Packet copy for the builder
   always_ff @(posedge user_clock) begin
      if (rx_valid_i) begin
         req_pkt_o <= rx_pkt_i;
      end
   end

   ////////////////////////////////////////////////////////////
   // A packet is either passed on or answered, never both
   a_fwd_or_reply: assert property (
      @(posedge user_clock) disable iff (reset_1)
      req_valid_o |-> !(req_forward_o && req_reply_o)
   ) else $error("forward and reply requested together");

endmodule

/* rtl/tnet_time_counter.sv */
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// Absolute time counter of the node
// Clear, load, offset add, else free-run increment
////////////////////////////////////////////////////////////

module tnet_time_counter
   import time_pkg::*;
(
   input  logic       user_clock,
   input  logic       reset_1,
   input  time_ctrl_t time_ctrl_i,
   output time_t      time_o
);

   time_t   time_q;
   offset_t offset;

   assign offset = time_ctrl_i.value[OFFSET_W-1:0];  // Offset lives in low bits

   // Clear wins over load, load over add
   always_ff @(posedge user_clock) begin
      if (reset_1) begin
         time_q <= '0;
      end else if (time_ctrl_i.clear) begin
         time_q <= '0;
      end else if (time_ctrl_i.load) begin
         time_q <= time_ctrl_i.value;
      end else if (time_ctrl_i.add) begin
         time_q <= time_q + time_t'(offset);
      end else begin
         time_q <= time_q + time_t'(1);  // Free run
      end
   end

   assign time_o = time_q;

   ////////////////////////////////////////////////////////////
   // Decoder must never issue two commands in one cycle
   a_one_strobe: assert property (
      @(posedge user_clock) disable iff (reset_1)
      $onehot0({time_ctrl_i.clear, time_ctrl_i.load, time_ctrl_i.add})
   ) else $error("time control strobes overlap");

endmodule

/* rtl/tnet_tx_builder.sv */
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// Transmit builder
// Forward or time reply, held in one register until ready
////////////////////////////////////////////////////////////

module tnet_tx_builder
   import time_pkg::*, tnet_pkg::*;
#(
   parameter node_id_t NODE_ID = '0
)(
   input  logic      user_clock,
   input  logic      reset_1,
   input  logic      req_valid_i,
   input  logic      req_forward_i,
   input  logic      req_reply_i,
   input  tnet_pkt_t req_pkt_i,
   input  time_t     time_i,
   input  logic      tx_ready_i,
   output tnet_pkt_t tx_pkt_o,
   output logic      tx_valid_o,
   output logic      drop_o
);

   tx_state_e state_q;
   tx_state_e state_d;
   tnet_pkt_t reply_pkt;
   tnet_pkt_t next_pkt;
   logic      req_load;
   logic      slot_free;

   ////////////////////////////////////////////////////////////
   // Reply packet
   always_comb begin
      reply_pkt         = req_pkt_i;  // Keeps type and flags
      reply_pkt.cmd     = CMD_TIME_REPLY;
      reply_pkt.src     = NODE_ID;
      reply_pkt.dst     = req_pkt_i.src;
      reply_pkt.payload = {{(PAYLOAD_W-TIME_W){1'b0}}, time_i};  // Time before this edge
   end

   assign next_pkt  = req_reply_i ? reply_pkt : req_pkt_i;
   assign req_load  = req_valid_i && (req_forward_i || req_reply_i);
   assign slot_free = (state_q == TX_IDLE) || tx_ready_i;  // Empty or leaving now

   ////////////////////////////////////////////////////////////
   // FSM
   always_comb begin
      state_d = state_q;
      case (state_q)
         TX_IDLE: begin
            if (req_load) begin
               state_d = TX_HOLD;
            end
         end
         TX_HOLD: begin
            // Accepted and nothing new to send
            if (tx_ready_i && !req_load) begin
               state_d = TX_IDLE;
            end
         end
         default: state_d = TX_IDLE;
      endcase
   end

   always_ff @(posedge user_clock) begin
      if (reset_1) begin
         state_q <= TX_IDLE;
         drop_o  <= 1'b0;
      end else begin
         state_q <= state_d;
         drop_o  <= req_load && !slot_free;  // Held packet not taken
      end
   end

   // Transmit register
   always_ff @(posedge user_clock) begin
      if (req_load && slot_free) begin
         tx_pkt_o <= next_pkt;
      end
   end

   assign tx_valid_o = (state_q == TX_HOLD);

   ////////////////////////////////////////////////////////////
   // Ring output holds still under back-pressure
   a_tx_stable: assert property (
      @(posedge user_clock) disable iff (reset_1)
      tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_pkt_o)
   ) else $error("tx_pkt_o changed while not accepted");

endmodule

/* tests/tb_tnet_node.sv */
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// Testbench for the timing network node
// Clock, reset, random packets, ready toggling, timeout
////////////////////////////////////////////////////////////

module tb_tnet_node
   import time_pkg::*, tnet_pkg::*;
();

   localparam int       NUM_PKTS       = 300;
   localparam int       CLK_PERIOD     = 8;
   localparam int       RESET_CYCLES   = 4;
   localparam int       MAX_GAP        = 6;
   localparam int       DRIVE_DELAY    = 1;
   localparam int       TIMEOUT_CYCLES = NUM_PKTS * 8 + 200;
   localparam node_id_t NODE_ID        = 9'd3;

   logic      user_clock;
   logic      reset_1;
   tnet_pkt_t rx_pkt;
   logic      rx_valid;
   logic      tx_ready;
   tnet_pkt_t tx_pkt;
   logic      tx_valid;
   time_t     time_val;
   logic      drop;
   int        err_cnt;
   int        chk_cnt;
   int        cycle_cnt = 0;
   integer    seed;

   tnet_node #(.NODE_ID(NODE_ID)) tnet_node_inst (
      .user_clock (user_clock),
      .reset_1    (reset_1),
      .rx_pkt_i   (rx_pkt),
      .rx_valid_i (rx_valid),
      .tx_ready_i (tx_ready),
      .tx_pkt_o   (tx_pkt),
      .tx_valid_o (tx_valid),
      .time_o     (time_val),
      .drop_o     (drop)
   );

   tnet_checker #(.NODE_ID(NODE_ID)) checker_inst (
      .user_clock (user_clock),
      .reset_1    (reset_1),
      .rx_pkt_i   (rx_pkt),
      .rx_valid_i (rx_valid),
      .tx_ready_i (tx_ready),
      .tx_pkt_i   (tx_pkt),
      .tx_valid_i (tx_valid),
      .time_i     (time_val),
      .drop_i     (drop),
      .err_cnt_o  (err_cnt),
      .chk_cnt_o  (chk_cnt)
   );

   initial begin
      user_clock = 1'b0;
      forever #(CLK_PERIOD/2) user_clock = ~user_clock;
   end

   // One clock with ready high about three times in four
   task automatic next_cycle();
      @(posedge user_clock);
      #DRIVE_DELAY;
      tx_ready = (($random(seed) & 3) != 0);
   endtask

   function automatic tnet_pkt_t random_pkt();
      tnet_pkt_t p;
      int        sel;
      p.ptype = $random(seed);
      p.flags = $random(seed);
      p.src   = $random(seed);
      sel     = $random(seed) & 3;
      p.dst   = (sel == 0) ? NODE_ID : (sel == 1) ? BCAST_ID : node_id_t'($random(seed));
      sel     = $random(seed) & 7;
      case (sel)
         0:       p.cmd = CMD_NOP;
         1:       p.cmd = CMD_RST_TIME;
         2:       p.cmd = CMD_SET_TIME;
         3:       p.cmd = CMD_UPDT_OFFSET;
         4, 5:    p.cmd = CMD_GET_TIME;   // Queries twice as often
         6:       p.cmd = CMD_TIME_REPLY;
         default: p.cmd = tnet_cmd_e'($random(seed) & 63);  // Junk command
      endcase
      p.payload[31:0]  = $random(seed);
      p.payload[63:32] = $random(seed);
      p.payload[95:64] = $random(seed);
      return p;
   endfunction

   ////////////////////////////////////////////////////////////
   // Stimulus
   initial begin : stimulus
      int gap;
      seed     = 32'h94;
      reset_1  = 1'b1;
      rx_pkt   = '0;
      rx_valid = 1'b0;
      tx_ready = 1'b0;
      repeat (RESET_CYCLES) @(posedge user_clock);
      #DRIVE_DELAY;
      reset_1 = 1'b0;
      for (int i = 0; i < NUM_PKTS; i++) begin
         rx_pkt   = random_pkt();
         rx_valid = 1'b1;
         next_cycle();
         rx_valid = 1'b0;
         gap      = $unsigned($random(seed)) % (MAX_GAP + 1);
         repeat (gap) next_cycle();
      end
      repeat (2) next_cycle();   // Last request reaches the builder
      while (tx_valid) next_cycle();
      checker_inst.check_leftovers();
      repeat (2) next_cycle();
      $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   always @(posedge user_clock) cycle_cnt <= cycle_cnt + 1;

   initial begin
      wait (cycle_cnt >= TIMEOUT_CYCLES);
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
      $display("Some tests failed");
      $finish;
   end

endmodule

/* tests/tnet_checker.sv */
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// Checker for the timing network node
// Reference model of time and transmit traffic, error counts
////////////////////////////////////////////////////////////

module tnet_checker
   import time_pkg::*, tnet_pkg::*;
#(
   parameter node_id_t NODE_ID = 9'd3
)(
   input  logic      user_clock,
   input  logic      reset_1,
   input  tnet_pkt_t rx_pkt_i,
   input  logic      rx_valid_i,
   input  logic      tx_ready_i,
   input  tnet_pkt_t tx_pkt_i,
   input  logic      tx_valid_i,
   input  time_t     time_i,
   input  logic      drop_i,
   output int        err_cnt_o,
   output int        chk_cnt_o
);

   tnet_pkt_t exp_q[$];    // Packets still to leave the node
   time_t     m_time;
   logic      m_tx_valid;
   logic      m_drop;
   logic      m_held;      // No handover at the last edge
   tnet_pkt_t last_tx;
   logic      checks_on;
   logic      own;
   logic      bcast;
   tnet_pkt_t s_pkt;       // Packet in the decoder stage
   logic      s_clear;
   logic      s_load;
   logic      s_add;
   logic      s_fwd;
   logic      s_reply;

   initial begin
      err_cnt_o = 0;
      chk_cnt_o = 0;
      checks_on = 1'b0;
   end

   task automatic compare(input string name, input logic [127:0] exp,
                          input logic [127:0] act);
      chk_cnt_o++;
      if (exp !== act) begin
         err_cnt_o++;
         $display("Fail at %0t: %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   // Answer to a time query with addresses swapped
   function automatic tnet_pkt_t time_reply(input tnet_pkt_t query, input time_t t);
      tnet_pkt_t r;
      r.ptype   = query.ptype;
      r.cmd     = CMD_TIME_REPLY;
      r.flags   = query.flags;
      r.src     = NODE_ID;
      r.dst     = query.src;
      r.payload = payload_t'(t);
      return r;
   endfunction

   ////////////////////////////////////////////////////////////
   // Model state for the coming rising edge
   task automatic step_model();
      m_held = m_tx_valid && !tx_ready_i;
      m_drop = 1'b0;
      if (m_tx_valid && tx_ready_i) begin
         if (exp_q.size() == 0) begin
            err_cnt_o++;
            $display("Packet handed over at %0t while none was expected", $time);
         end else begin
            compare("tx_pkt_o", exp_q.pop_front(), tx_pkt_i);
         end
      end
      if (s_fwd || s_reply) begin
         if (m_held) begin
            m_drop = 1'b1;   // Held packet not taken so the request is lost
         end else begin
            exp_q.push_back(s_reply ? time_reply(s_pkt, m_time) : s_pkt);
            m_tx_valid = 1'b1;
         end
      end else if (tx_ready_i) begin
         m_tx_valid = 1'b0;
      end
      // Time after the edge with clear over load over add
      case (1'b1)
         s_clear: m_time = '0;
         s_load:  m_time = s_pkt.payload[TIME_W-1:0];
         s_add:   m_time = m_time + time_t'(s_pkt.payload[OFFSET_W-1:0]);
         default: m_time = m_time + time_t'(1);
      endcase
      {s_clear, s_load, s_add, s_fwd, s_reply} = '0;
      if (rx_valid_i) begin
         bcast   = (rx_pkt_i.dst == '1);
         own     = (rx_pkt_i.dst == NODE_ID) && !bcast;
         s_pkt   = rx_pkt_i;
         s_fwd   = !own;                   // Broadcasts travel on too
         s_reply = own && (rx_pkt_i.cmd == CMD_GET_TIME);
         if (own || bcast) begin
            s_clear = (rx_pkt_i.cmd == CMD_RST_TIME);
            s_load  = (rx_pkt_i.cmd == CMD_SET_TIME);
            s_add   = (rx_pkt_i.cmd == CMD_UPDT_OFFSET);
         end
      end
   endtask

   // Outputs settled and inputs set for the next rise at the falling edge
   always @(negedge user_clock) begin
      if (checks_on) begin
         compare("time_o", m_time, time_i);
         compare("tx_valid_o", m_tx_valid, tx_valid_i);
         compare("drop_o", m_drop, drop_i);
         if (m_held) begin
            compare("tx_pkt_o", last_tx, tx_pkt_i);  // Stable under back-pressure
         end
      end
      last_tx = tx_pkt_i;
      if (reset_1) begin
         exp_q.delete();
         m_time     = '0;
         m_tx_valid = 1'b0;
         m_drop     = 1'b0;
         m_held     = 1'b0;
         {s_clear, s_load, s_add, s_fwd, s_reply} = '0;
         checks_on  = 1'b1;
      end else begin
         step_model();
      end
   end

   task automatic check_leftovers();
      chk_cnt_o++;
      if (exp_q.size() != 0) begin
         err_cnt_o++;
         $display("%0d expected packets never left the node", exp_q.size());
      end
   endtask

endmodule

/* tnet_node.f */
rtl/time_pkg.sv
rtl/tnet_pkg.sv
rtl/tnet_time_counter.sv
rtl/tnet_rx_decoder.sv
rtl/tnet_tx_builder.sv
rtl/tnet_node.sv
tests/tnet_checker.sv
tests/tb_tnet_node.sv
